//--- flist.f
usb_pkt_pkg.sv
cap_regs_pkg.sv
capture_ifs.sv
packet_capture.sv
timestamp_counter.sv
capture_fifo.sv
control_regs.sv
usb_capture_top.sv
tb_usb_capture.sv

//--- Bender.yml
package:
  name: usb_capture

sources:
  - usb_pkt_pkg.sv
  - cap_regs_pkg.sv
  - capture_ifs.sv
  - packet_capture.sv
  - timestamp_counter.sv
  - capture_fifo.sv
  - control_regs.sv
  - usb_capture_top.sv
  - target: test
    files:
      - tb_usb_capture.sv

//--- tb_usb_capture.sv
module tb_usb_capture;
    timeunit 1ns;
    timeprecision 100ps;

    import usb_pkt_pkg::*;
    import cap_regs_pkg::*;

    localparam int DEPTH     = 64;   // 2**FIFO_ADDR_W
    localparam int RESP_WAIT = 10;   // Cycles allowed for a register answer
    localparam int MAX_READS = 200;  // Drain gives up after this many requests

    // One expected buffer entry
    typedef struct packed {
        dir_t  dir;
        logic  sop;
        logic  eop;
        byte_t data;
    } entry_t;

    logic      clk_120mhz = 1'b0;
    logic      rst_n;
    byte_t     host_data_i;
    logic      host_valid_i, host_sop_i, host_eop_i, host_crc_ok_i;
    byte_t     dev_data_i;
    logic      dev_valid_i, dev_sop_i, dev_eop_i, dev_crc_ok_i;
    logic      rd_req_i;
    byte_t     cmd_data_i;
    logic      cmd_valid_i;
    byte_t     rd_data_o;
    logic      rd_sop_o, rd_eop_o, rd_valid_o, rd_empty_o;
    dir_t      rd_dir_o;
    ts_short_t rd_ts_o;
    byte_t     resp_data_o;
    logic      resp_valid_o;

    // Reference model of buffer and registers
    entry_t    exp_q[$];
    entry_t    exp_head;
    byte_t     m_ctrl     = 8'h01;
    pid_mask_t m_mask     = '0;
    logic      m_drop     = 1'b0;   // Rest of packet lost after full
    int        exp_pkts   = 0;
    int        exp_crc    = 0;
    int        exp_sof    = 0;
    int        n_reads    = 0;
    ts_short_t last_ts    = '0;     // Stamp of the last packet read
    logic      write_pending = 1'b0; // Data byte of a write still to come
    int        seed       = 25147;
    string     test_name  = "reset";
    int        data_errs  = 0;
    int        reg_errs   = 0;
    int        other_errs = 0;
    int        n_drained;

    usb_capture_top #(.FIFO_ADDR_W(6), .TICK_DIV(1)) dut (.*);

    always #5 clk_120mhz = ~clk_120mhz;

    //////////////////////////////////////////////////
    // Checking
    //////////////////////////////////////////////////

    task automatic report_mismatch(input string field, input logic [15:0] exp,
                                   input logic [15:0] act);
        data_errs++;
        $display("[ERROR] %s %s: expected 0x%0h, actual 0x%0h", test_name, field, exp, act);
    endtask

    // Read side sampled at the falling edge
    always @(negedge clk_120mhz) begin
        if (rst_n && rd_valid_o) begin
            n_reads++;
            if (exp_q.size() == 0) begin
                data_errs++;
                $display("%s: buffer returned an entry that was never expected", test_name);
            end else begin
                exp_head = exp_q.pop_front();
                assert (rd_data_o === exp_head.data)
                    else report_mismatch("rd_data_o", exp_head.data, rd_data_o);
                assert (rd_sop_o === exp_head.sop)
                    else report_mismatch("rd_sop_o", exp_head.sop, rd_sop_o);
                assert (rd_eop_o === exp_head.eop)
                    else report_mismatch("rd_eop_o", exp_head.eop, rd_eop_o);
                assert (rd_dir_o === exp_head.dir)
                    else report_mismatch("rd_dir_o", exp_head.dir, rd_dir_o);
            end
            if (rd_sop_o) begin
                assert (rd_ts_o >= last_ts) else begin
                    data_errs++;
                    $display("%s: timestamp went backwards from 0x%0h to 0x%0h",
                             test_name, last_ts, rd_ts_o);
                end
                last_ts = rd_ts_o;
            end else begin
                assert (rd_ts_o === last_ts) else report_mismatch("rd_ts_o", last_ts, rd_ts_o);
            end
        end
    end

    // Read port answers the cycle after a request
    assert property (@(posedge clk_120mhz) disable iff (!rst_n)
        rd_req_i && !rd_empty_o |=> rd_valid_o)
        else begin
            other_errs++;
            $display("%s: read request on a non-empty buffer gave no data", test_name);
        end

    // Register read answers exactly one cycle later
    assert property (@(posedge clk_120mhz) disable iff (!rst_n)
        cmd_valid_i && !cmd_data_i[CMD_WRITE_BIT] && !write_pending |=> resp_valid_o)
        else begin
            other_errs++;
            $display("%s: register read not answered one cycle later", test_name);
        end

    task automatic check_reg(input string name, input byte_t exp, input byte_t act);
        assert (act === exp) else begin
            reg_errs++;
            $display("[ERROR] %s %s: expected 0x%02h, actual 0x%02h", test_name, name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        assert (act == exp) else begin
            other_errs++;
            $display("[ERROR] %s %s: expected %0d, actual %0d", test_name, name, exp, act);
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    task automatic drive_beat(input dir_t dir, input byte_t b, input logic sop,
                              input logic eop, input logic crc_ok);
        host_valid_i  = (dir == DIR_HOST);
        host_data_i   = b;
        host_sop_i    = sop;
        host_eop_i    = eop;
        host_crc_ok_i = crc_ok;
        dev_valid_i   = (dir == DIR_DEVICE);
        dev_data_i    = b;
        dev_sop_i     = sop;
        dev_eop_i     = eop;
        dev_crc_ok_i  = crc_ok;
    endtask

    // Buffer model drops the rest of a packet once full
    task automatic push_expected(input entry_t e);
        if (exp_q.size() >= DEPTH) begin
            m_drop = 1'b1;
        end else begin
            if (e.sop) m_drop = 1'b0;
            if (!m_drop) begin
                exp_q.push_back(e);
                if (e.eop) exp_pkts++;
            end
        end
    endtask

    task automatic send_packet(input dir_t dir, input pid_t pid, input int len,
                               input logic crc_ok);
        byte_t b;
        logic  keep;
        int    i;
        keep = m_ctrl[0] && !(m_ctrl[1] && m_mask[pid]);   // Fixed at sop
        if (dir == DIR_HOST && pid == PID_SOF) exp_sof++;
        if (!crc_ok) exp_crc++;
        for (i = 0; i < len; i++) begin
            b = (i == 0) ? {~pid, pid} : byte_t'($random(seed));
            @(posedge clk_120mhz);
            #1;
            drive_beat(dir, b, i == 0, i == len - 1, (i == len - 1) ? crc_ok : 1'b1);
            if (keep) push_expected('{dir, i == 0, i == len - 1, b});
        end
        @(posedge clk_120mhz);
        #1;
        host_valid_i = 1'b0;
        dev_valid_i  = 1'b0;
        @(posedge clk_120mhz);   // Gap between packets
    endtask

    task automatic reg_write(input reg_addr_t addr, input byte_t data);
        @(posedge clk_120mhz);
        #1;
        cmd_data_i    = {1'b1, 3'b000, addr};
        cmd_valid_i   = 1'b1;
        write_pending = 1'b1;
        @(posedge clk_120mhz);
        #1;
        cmd_data_i = data;
        @(posedge clk_120mhz);
        #1;
        cmd_valid_i   = 1'b0;
        write_pending = 1'b0;
        case (addr)
            REG_CTRL:    m_ctrl       = data;
            REG_MASK_LO: m_mask[7:0]  = data;
            REG_MASK_HI: m_mask[15:8] = data;
            default:     ;
        endcase
    endtask

    task automatic reg_read(input reg_addr_t addr, output byte_t data);
        int waited;
        waited = 0;
        @(posedge clk_120mhz);
        #1;
        cmd_data_i  = {4'h0, addr};
        cmd_valid_i = 1'b1;
        @(posedge clk_120mhz);
        #1;
        cmd_valid_i = 1'b0;
        @(negedge clk_120mhz);
        while (!resp_valid_o && waited < RESP_WAIT) begin
            @(negedge clk_120mhz);
            waited++;
        end
        if (resp_valid_o) begin
            data = resp_data_o;
        end else begin
            other_errs++;
            data = 'x;
            $display("%s: no register response within %0d cycles", test_name, RESP_WAIT);
        end
    endtask

    task automatic read_check(input string name, input reg_addr_t addr, input byte_t exp);
        byte_t act;
        reg_read(addr, act);
        check_reg(name, exp, act);
    endtask

    // Pulls entries until empty while the checker pops the model
    task automatic drain(output int n_entries);
        int start_reads;
        int guard;
        start_reads = n_reads;
        guard       = 0;
        @(posedge clk_120mhz);
        #1;
        while (!rd_empty_o && guard < MAX_READS) begin
            rd_req_i = 1'b1;
            @(posedge clk_120mhz);
            #1;
            rd_req_i = 1'b0;
            guard++;
        end
        if (!rd_empty_o) begin
            other_errs++;
            $display("%s: buffer still not empty after %0d reads", test_name, MAX_READS);
        end
        repeat (2) @(posedge clk_120mhz);
        #1;
        n_entries = n_reads - start_reads;
        if (exp_q.size() != 0) begin
            other_errs++;
            $display("%s: %0d expected entries were never read back", test_name, exp_q.size());
            exp_q.delete();
        end
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        int k;
        rst_n = 1'b0;
        drive_beat(DIR_HOST, 8'h00, 1'b0, 1'b0, 1'b1);
        host_valid_i = 1'b0;
        dev_valid_i  = 1'b0;
        rd_req_i     = 1'b0;
        cmd_data_i   = 8'h00;
        cmd_valid_i  = 1'b0;
        repeat (5) @(posedge clk_120mhz);
        #1;
        rst_n = 1'b1;

        // Reset state
        test_name = "reset";
        check_reg("rd_empty_o", 8'h01, {7'b0, rd_empty_o});
        read_check("REG_CTRL", REG_CTRL, 8'h01);
        read_check("REG_STATUS", REG_STATUS, 8'h02);   // Empty without overflow
        read_check("REG_PKT_LO", REG_PKT_LO, 8'h00);
        read_check("REG_PKT_HI", REG_PKT_HI, 8'h00);
        read_check("REG_CRC_LO", REG_CRC_LO, 8'h00);
        read_check("REG_SOF_LO", REG_SOF_LO, 8'h00);
        @(posedge clk_120mhz);
        #1;
        rd_req_i = 1'b1;   // Must be ignored
        @(posedge clk_120mhz);
        #1;
        rd_req_i = 1'b0;
        repeat (2) @(posedge clk_120mhz);

        // Alternating sides with lengths 1 to 7
        test_name = "capture order";
        send_packet(DIR_HOST,   4'h1, 5, 1'b1);
        send_packet(DIR_DEVICE, 4'hB, 7, 1'b1);
        send_packet(DIR_HOST,   4'h9, 3, 1'b1);
        send_packet(DIR_DEVICE, 4'h2, 1, 1'b1);
        send_packet(DIR_HOST,   4'hD, 6, 1'b1);
        send_packet(DIR_DEVICE, 4'h3, 4, 1'b1);
        read_check("REG_PKT_LO", REG_PKT_LO, 8'd6);
        read_check("REG_PKT_HI", REG_PKT_HI, 8'd0);
        drain(n_drained);
        check_count("entries drained", 26, n_drained);

        // Filter on DATA0 then capture toggled mid-packet
        test_name = "filter and enable";
        reg_write(REG_MASK_LO, 8'h08);
        reg_write(REG_CTRL, 8'h03);
        send_packet(DIR_HOST,   PID_DATA0, 4, 1'b1);
        send_packet(DIR_DEVICE, 4'hB, 4, 1'b1);
        send_packet(DIR_HOST,   4'h1, 3, 1'b1);
        send_packet(DIR_DEVICE, PID_DATA0, 6, 1'b1);
        fork
            send_packet(DIR_HOST, 4'h2, 12, 1'b1);   // Started while enabled
            begin
                repeat (3) @(posedge clk_120mhz);
                reg_write(REG_CTRL, 8'h00);
            end
        join
        send_packet(DIR_DEVICE, 4'hB, 4, 1'b1);
        fork
            send_packet(DIR_DEVICE, 4'hB, 12, 1'b1); // Started while disabled
            begin
                repeat (3) @(posedge clk_120mhz);
                reg_write(REG_CTRL, 8'h01);
            end
        join
        send_packet(DIR_HOST, 4'h1, 5, 1'b1);
        drain(n_drained);
        check_count("entries drained", 24, n_drained);

        // CRC errors and SOF counted whatever is stored
        test_name = "counters";
        reg_write(REG_CTRL, 8'h03);
        send_packet(DIR_HOST,   PID_DATA0, 4, 1'b0);
        send_packet(DIR_DEVICE, 4'hB, 3, 1'b0);
        read_check("REG_CRC_LO", REG_CRC_LO, byte_t'(exp_crc));
        reg_write(REG_CTRL, 8'h00);
        send_packet(DIR_HOST,   PID_SOF, 3, 1'b1);
        send_packet(DIR_HOST,   PID_SOF, 3, 1'b1);
        send_packet(DIR_DEVICE, PID_SOF, 3, 1'b1);   // Device side not a frame start
        read_check("REG_SOF_LO", REG_SOF_LO, byte_t'(exp_sof));
        drain(n_drained);
        check_count("entries drained", 3, n_drained);

        // 80 bytes into 64 entries
        test_name = "overflow";
        reg_write(REG_CTRL, 8'h01);
        for (k = 0; k < 8; k++) begin
            send_packet((k % 2 == 0) ? DIR_HOST : DIR_DEVICE,
                        (k % 2 == 0) ? 4'h1 : 4'hB, 10, 1'b1);
        end
        read_check("REG_STATUS", REG_STATUS, 8'h01);
        drain(n_drained);
        check_count("entries drained", 64, n_drained);
        read_check("REG_STATUS", REG_STATUS, 8'h03);   // Overflow stays set
        send_packet(DIR_HOST, 4'h9, 6, 1'b1);
        drain(n_drained);
        check_count("entries after overflow", 6, n_drained);
        read_check("REG_PKT_LO", REG_PKT_LO, byte_t'(exp_pkts));

        $display("Errors: %0d data, %0d register, %0d other", data_errs, reg_errs, other_errs);
        if (data_errs + reg_errs + other_errs == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- usb_capture_top.sv
module usb_capture_top #(
    parameter int FIFO_ADDR_W = 6,
    parameter int TICK_DIV    = 1
) (
    input  logic                   clk_120mhz,
    input  logic                   rst_n,
    // Host side stream
    input  usb_pkt_pkg::byte_t     host_data_i,
    input  logic                   host_valid_i,
    input  logic                   host_sop_i,
    input  logic                   host_eop_i,
    input  logic                   host_crc_ok_i,
    // Device side stream
    input  usb_pkt_pkg::byte_t     dev_data_i,
    input  logic                   dev_valid_i,
    input  logic                   dev_sop_i,
    input  logic                   dev_eop_i,
    input  logic                   dev_crc_ok_i,
    // Buffer read port
    input  logic                   rd_req_i,
    output usb_pkt_pkg::byte_t     rd_data_o,
    output logic                   rd_sop_o,
    output logic                   rd_eop_o,
    output usb_pkt_pkg::dir_t      rd_dir_o,
    output usb_pkt_pkg::ts_short_t rd_ts_o,
    output logic                   rd_valid_o,
    output logic                   rd_empty_o,
    // Command port
    input  usb_pkt_pkg::byte_t     cmd_data_i,
    input  logic                   cmd_valid_i,
    output usb_pkt_pkg::byte_t     resp_data_o,
    output logic                   resp_valid_o
);
    import usb_pkt_pkg::*;
    import cap_regs_pkg::*;

    pkt_stream_if host_if ();
    pkt_stream_if dev_if ();
    cap_write_if  wr_if ();

    logic      cfg_capture_en;
    logic      cfg_filter_en;
    pid_mask_t cfg_mask;
    ts_t       ts;
    logic      sof_seen;
    cnt16_t    crc_err_count;
    cnt16_t    sof_count;
    cnt16_t    pkt_count;
    logic      overflow;

    // Pack plain stream ports
    assign host_if.data   = host_data_i;
    assign host_if.valid  = host_valid_i;
    assign host_if.sop    = host_sop_i;
    assign host_if.eop    = host_eop_i;
    assign host_if.crc_ok = host_crc_ok_i;
    assign dev_if.data    = dev_data_i;
    assign dev_if.valid   = dev_valid_i;
    assign dev_if.sop     = dev_sop_i;
    assign dev_if.eop     = dev_eop_i;
    assign dev_if.crc_ok  = dev_crc_ok_i;

    packet_capture u_capture (
        .clk_120mhz      (clk_120mhz),
        .rst_n           (rst_n),
        .host_s          (host_if.sink),
        .dev_s           (dev_if.sink),
        .wr              (wr_if.source),
        .cfg_capture_en_i(cfg_capture_en),
        .cfg_filter_en_i (cfg_filter_en),
        .cfg_mask_i      (cfg_mask),
        .ts_i            (ts),
        .sof_seen_o      (sof_seen),
        .crc_err_count_o (crc_err_count)
    );

    timestamp_counter #(.TICK_DIV(TICK_DIV)) u_ts (
        .clk_120mhz (clk_120mhz),
        .rst_n      (rst_n),
        .sof_seen_i (sof_seen),
        .ts_o       (ts),
        .sof_count_o(sof_count)
    );

    capture_fifo #(.FIFO_ADDR_W(FIFO_ADDR_W)) u_fifo (
        .clk_120mhz (clk_120mhz),
        .rst_n      (rst_n),
        .wr         (wr_if.sink),
        .rd_req_i   (rd_req_i),
        .rd_data_o  (rd_data_o),
        .rd_sop_o   (rd_sop_o),
        .rd_eop_o   (rd_eop_o),
        .rd_dir_o   (rd_dir_o),
        .rd_ts_o    (rd_ts_o),
        .rd_valid_o (rd_valid_o),
        .empty_o    (rd_empty_o),
        .overflow_o (overflow),
        .pkt_count_o(pkt_count)
    );

    control_regs u_regs (
        .clk_120mhz      (clk_120mhz),
        .rst_n           (rst_n),
        .cmd_data_i      (cmd_data_i),
        .cmd_valid_i     (cmd_valid_i),
        .pkt_count_i     (pkt_count),
        .crc_err_count_i (crc_err_count),
        .sof_count_i     (sof_count),
        .overflow_i      (overflow),
        .empty_i         (rd_empty_o),
        .resp_data_o     (resp_data_o),
        .resp_valid_o    (resp_valid_o),
        .cfg_capture_en_o(cfg_capture_en),
        .cfg_filter_en_o (cfg_filter_en),
        .cfg_mask_o      (cfg_mask)
    );

endmodule

//--- control_regs.sv
module control_regs (
    input  logic                     clk_120mhz,
    input  logic                     rst_n,
    input  usb_pkt_pkg::byte_t       cmd_data_i,
    input  logic                     cmd_valid_i,
    input  usb_pkt_pkg::cnt16_t      pkt_count_i,
    input  usb_pkt_pkg::cnt16_t      crc_err_count_i,
    input  usb_pkt_pkg::cnt16_t      sof_count_i,
    input  logic                     overflow_i,
    input  logic                     empty_i,
    output usb_pkt_pkg::byte_t       resp_data_o,
    output logic                     resp_valid_o,
    output logic                     cfg_capture_en_o,
    output logic                     cfg_filter_en_o,
    output cap_regs_pkg::pid_mask_t  cfg_mask_o
);
    import usb_pkt_pkg::*;
    import cap_regs_pkg::*;

    typedef enum logic {
        CMD_IDLE,
        CMD_WAIT_DATA      // Write address seen, data byte next
    } cmd_state_t;

    cmd_state_t state_q;
    reg_addr_t  cmd_addr;
    reg_addr_t  addr_q;    // Target of pending write
    logic [1:0] ctrl_q;    // [1] filter en, [0] capture en
    pid_mask_t  mask_q;
    byte_t      rd_byte;

    assign cmd_addr         = cmd_data_i[3:0];
    assign cfg_capture_en_o = ctrl_q[0];
    assign cfg_filter_en_o  = ctrl_q[1];
    assign cfg_mask_o       = mask_q;

    //////////////////////////////////////////////////
    // Readback mux
    //////////////////////////////////////////////////

    always_comb begin
        case (cmd_addr)
            REG_CTRL:    rd_byte = {6'b0, ctrl_q};
            REG_MASK_LO: rd_byte = mask_q[7:0];
            REG_MASK_HI: rd_byte = mask_q[15:8];
            REG_PKT_LO:  rd_byte = pkt_count_i[7:0];
            REG_PKT_HI:  rd_byte = pkt_count_i[15:8];
            REG_CRC_LO:  rd_byte = crc_err_count_i[7:0];
            REG_STATUS:  rd_byte = {6'b0, empty_i, overflow_i};
            REG_SOF_LO:  rd_byte = sof_count_i[7:0];
            default:     rd_byte = '0;   // Unmapped
        endcase
    end

    //////////////////////////////////////////////////
    // Command FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk_120mhz or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= CMD_IDLE;
            resp_valid_o <= 1'b0;
            ctrl_q       <= CTRL_RESET[1:0];
            mask_q       <= MASK_RESET;
        end else begin
            resp_valid_o <= 1'b0;
            if (cmd_valid_i) begin
                case (state_q)
                    CMD_IDLE: begin
                        if (cmd_data_i[CMD_WRITE_BIT]) begin
                            state_q <= CMD_WAIT_DATA;
                        end else begin
                            resp_valid_o <= 1'b1;   // Read answers next cycle
                        end
                    end
                    CMD_WAIT_DATA: begin
                        state_q <= CMD_IDLE;
                        case (addr_q)               // Read-only targets ignored
                            REG_CTRL:    ctrl_q       <= cmd_data_i[1:0];
                            REG_MASK_LO: mask_q[7:0]  <= cmd_data_i;
                            REG_MASK_HI: mask_q[15:8] <= cmd_data_i;
                            default:     ;
                        endcase
                    end
                    default: state_q <= CMD_IDLE;
                endcase
            end
        end
    end

    // Address and response byte
    always_ff @(posedge clk_120mhz) begin
        if (cmd_valid_i && state_q == CMD_IDLE) begin
            addr_q      <= cmd_addr;
            resp_data_o <= rd_byte;
        end
    end

    assert property (@(posedge clk_120mhz) disable iff (!rst_n)
        resp_valid_o |=> !resp_valid_o)
        else $error("Response valid two cycles in a row");

endmodule

//--- capture_fifo.sv
module capture_fifo #(
    parameter int FIFO_ADDR_W = 6
) (
    input  logic                   clk_120mhz,
    input  logic                   rst_n,
    cap_write_if.sink              wr,
    input  logic                   rd_req_i,
    output usb_pkt_pkg::byte_t     rd_data_o,
    output logic                   rd_sop_o,
    output logic                   rd_eop_o,
    output usb_pkt_pkg::dir_t      rd_dir_o,
    output usb_pkt_pkg::ts_short_t rd_ts_o,
    output logic                   rd_valid_o,
    output logic                   empty_o,
    output logic                   overflow_o,
    output usb_pkt_pkg::cnt16_t    pkt_count_o
);
    import usb_pkt_pkg::*;

    localparam int DEPTH = 1 << FIFO_ADDR_W;

    logic [ENTRY_W-1:0]     mem [DEPTH];
    logic [ENTRY_W-1:0]     rd_entry;   // Registered read word
    logic [FIFO_ADDR_W-1:0] wr_ptr;
    logic [FIFO_ADDR_W-1:0] rd_ptr;
    logic [FIFO_ADDR_W:0]   count_q;    // One extra bit for full
    logic                   full;
    logic                   drop_q;     // Rest of packet discarded
    logic                   wr_accept;
    logic                   rd_fire;

    assign full      = (count_q == (FIFO_ADDR_W + 1)'(DEPTH));
    assign empty_o   = (count_q == '0);
    assign wr_accept = wr.wr_valid & ~full & (~drop_q | wr.wr_sop);
    assign rd_fire   = rd_req_i & ~empty_o;   // Empty requests ignored

    //////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////

    always_ff @(posedge clk_120mhz) begin
        if (wr_accept) begin
            mem[wr_ptr] <= {wr.wr_dir, wr.wr_sop, wr.wr_eop, wr.wr_ts, wr.wr_data};
        end
        if (rd_fire) begin
            rd_entry <= mem[rd_ptr];
        end
    end

    // Unpack read word
    assign rd_dir_o  = dir_t'(rd_entry[ENTRY_W-1]);
    assign rd_sop_o  = rd_entry[ENTRY_W-2];
    assign rd_eop_o  = rd_entry[ENTRY_W-3];
    assign rd_ts_o   = rd_entry[$bits(byte_t) +: $bits(ts_short_t)];
    assign rd_data_o = rd_entry[$bits(byte_t)-1:0];

    //////////////////////////////////////////////////
    // Pointers, occupancy, flags
    //////////////////////////////////////////////////

    always_ff @(posedge clk_120mhz or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count_q     <= '0;
            drop_q      <= 1'b0;
            overflow_o  <= 1'b0;
            pkt_count_o <= '0;
            rd_valid_o  <= 1'b0;
        end else begin
            rd_valid_o <= rd_fire;
            if (wr_accept) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_accept, rd_fire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;   // Both or neither
            endcase
            // Full write starts a drop, next sop with room ends it
            if (wr.wr_valid) begin
                if (full) begin
                    drop_q     <= 1'b1;
                    overflow_o <= 1'b1;   // Sticky until reset
                end else if (wr.wr_sop) begin
                    drop_q <= 1'b0;
                end
            end
            if (wr_accept && wr.wr_eop) begin
                pkt_count_o <= pkt_count_o + 1'b1;
            end
        end
    end

    assert property (@(posedge clk_120mhz) disable iff (!rst_n) count_q <= DEPTH)
        else $error("Buffer occupancy above depth");

    assert property (@(posedge clk_120mhz) disable iff (!rst_n)
        rd_req_i && empty_o |=> !rd_valid_o)
        else $error("Read data returned for a request on an empty buffer");

endmodule

//--- timestamp_counter.sv
module timestamp_counter #(
    parameter int TICK_DIV = 1
) (
    input  logic                clk_120mhz,
    input  logic                rst_n,
    input  logic                sof_seen_i,
    output usb_pkt_pkg::ts_t    ts_o,
    output usb_pkt_pkg::cnt16_t sof_count_o
);
    // At least one bit, even when not dividing
    localparam int DIV_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [DIV_W-1:0] presc_q;
    logic             tick;     // One clock every TICK_DIV

    assign tick = (presc_q == DIV_W'(TICK_DIV - 1));

    // Prescaler and tick counter
    always_ff @(posedge clk_120mhz or negedge rst_n) begin
        if (!rst_n) begin
            presc_q <= '0;
            ts_o    <= '0;
        end else begin
            presc_q <= tick ? '0 : presc_q + 1'b1;
            if (tick) begin
                ts_o <= ts_o + 1'b1;   // Wraps silently
            end
        end
    end

    // Frame bookkeeping
    always_ff @(posedge clk_120mhz or negedge rst_n) begin
        if (!rst_n) begin
            sof_count_o <= '0;
        end else if (sof_seen_i) begin
            sof_count_o <= sof_count_o + 1'b1;
        end
    end

endmodule

//--- packet_capture.sv
module packet_capture (
    input  logic                    clk_120mhz,
    input  logic                    rst_n,
    pkt_stream_if.sink              host_s,
    pkt_stream_if.sink              dev_s,
    cap_write_if.source             wr,
    input  logic                    cfg_capture_en_i,
    input  logic                    cfg_filter_en_i,
    input  cap_regs_pkg::pid_mask_t cfg_mask_i,
    input  usb_pkt_pkg::ts_t        ts_i,
    output logic                    sof_seen_o,
    output usb_pkt_pkg::cnt16_t     crc_err_count_o
);
    import usb_pkt_pkg::*;

    // Merged beat of whichever side is talking
    logic      beat_valid;
    byte_t     beat_data;
    logic      beat_sop;
    logic      beat_eop;
    logic      beat_crc_ok;
    dir_t      beat_dir;
    pid_t      beat_pid;

    logic      keep_sop;    // Decision for a packet starting now
    logic      keep_q;      // Decision held until eop
    logic      keep_beat;
    ts_short_t ts_q;        // Stamp taken at sop

    //////////////////////////////////////////////////
    // Stream select
    //////////////////////////////////////////////////

    // Half duplex, host wins only by convention
    assign beat_valid  = host_s.valid | dev_s.valid;
    assign beat_dir    = host_s.valid ? DIR_HOST : DIR_DEVICE;
    assign beat_data   = host_s.valid ? host_s.data   : dev_s.data;
    assign beat_sop    = host_s.valid ? host_s.sop    : dev_s.sop;
    assign beat_eop    = host_s.valid ? host_s.eop    : dev_s.eop;
    assign beat_crc_ok = host_s.valid ? host_s.crc_ok : dev_s.crc_ok;
    assign beat_pid    = beat_data[3:0];   // PID nibble, valid on sop only

    // Drop if capture off or PID masked
    assign keep_sop  = cfg_capture_en_i & ~(cfg_filter_en_i & cfg_mask_i[beat_pid]);
    assign keep_beat = beat_sop ? keep_sop : keep_q;

    // Config sampled once per packet
    always_ff @(posedge clk_120mhz or negedge rst_n) begin
        if (!rst_n) begin
            keep_q <= 1'b0;
        end else if (beat_valid && beat_sop) begin
            keep_q <= keep_sop;
        end
    end

    always_ff @(posedge clk_120mhz) begin
        if (beat_valid && beat_sop) begin
            ts_q <= ts_short_t'(ts_i);  // Low bits only
        end
    end

    //////////////////////////////////////////////////
    // Buffer write, one cycle latency
    //////////////////////////////////////////////////

    always_ff @(posedge clk_120mhz or negedge rst_n) begin
        if (!rst_n) begin
            wr.wr_valid <= 1'b0;
        end else begin
            wr.wr_valid <= beat_valid & keep_beat;
        end
    end

    always_ff @(posedge clk_120mhz) begin
        wr.wr_data <= beat_data;
        wr.wr_sop  <= beat_sop;
        wr.wr_eop  <= beat_eop;
        wr.wr_dir  <= beat_dir;
        wr.wr_ts   <= beat_sop ? ts_short_t'(ts_i) : ts_q;  // Same stamp for all beats
    end

    // Event counters see every packet, kept or not
    always_ff @(posedge clk_120mhz or negedge rst_n) begin
        if (!rst_n) begin
            sof_seen_o      <= 1'b0;
            crc_err_count_o <= '0;
        end else begin
            sof_seen_o <= host_s.valid & host_s.sop & (pid_t'(host_s.data[3:0]) == PID_SOF);
            if (beat_valid && beat_eop && !beat_crc_ok) begin
                crc_err_count_o <= crc_err_count_o + 1'b1;
            end
        end
    end

    // Bus is half duplex
    assert property (@(posedge clk_120mhz) disable iff (!rst_n)
        !(host_s.valid && dev_s.valid))
        else $error("Host and device streams both valid in one cycle");

endmodule

//--- capture_ifs.sv
// Decoded packet stream from one side of the bus
interface pkt_stream_if;
    import usb_pkt_pkg::*;

    byte_t data;
    logic  valid;
    logic  sop;
    logic  eop;
    logic  crc_ok;   // Only meaningful on eop

    modport driver (output data, valid, sop, eop, crc_ok);
    modport sink   (input  data, valid, sop, eop, crc_ok);
endinterface

// Write strobe into the capture buffer
interface cap_write_if;
    import usb_pkt_pkg::*;

    logic      wr_valid;   // No ready, plain strobe
    byte_t     wr_data;
    logic      wr_sop;
    logic      wr_eop;
    dir_t      wr_dir;
    ts_short_t wr_ts;      // Timestamp of the packet's sop

    modport source (output wr_valid, wr_data, wr_sop, wr_eop, wr_dir, wr_ts);
    modport sink   (input  wr_valid, wr_data, wr_sop, wr_eop, wr_dir, wr_ts);
endinterface

//--- cap_regs_pkg.sv
package cap_regs_pkg;

    typedef logic [3:0]  reg_addr_t;
    typedef logic [15:0] pid_mask_t;  // Bit n set drops PID n

    //////////////////////////////////////////////////
    // Register map
    //////////////////////////////////////////////////

    localparam reg_addr_t REG_CTRL    = 4'd0; // [0] capture en, [1] filter en
    localparam reg_addr_t REG_MASK_LO = 4'd1;
    localparam reg_addr_t REG_MASK_HI = 4'd2;
    localparam reg_addr_t REG_PKT_LO  = 4'd3; // Stored packets
    localparam reg_addr_t REG_PKT_HI  = 4'd4;
    localparam reg_addr_t REG_CRC_LO  = 4'd5;
    localparam reg_addr_t REG_STATUS  = 4'd6; // [0] overflow, [1] empty
    localparam reg_addr_t REG_SOF_LO  = 4'd7;

    // Command byte, low nibble is the address
    localparam int CMD_WRITE_BIT = 7;

    localparam logic [7:0] CTRL_RESET = 8'h01; // Capture on, filter off
    localparam pid_mask_t  MASK_RESET = '0;

endpackage

//--- usb_pkt_pkg.sv
package usb_pkt_pkg;

    //////////////////////////////////////////////////
    // Packet fields
    //////////////////////////////////////////////////

    typedef logic [7:0] byte_t;       // One packet byte
    typedef logic [3:0] pid_t;        // Low nibble of first byte

    localparam pid_t PID_DATA0 = 4'd3;
    localparam pid_t PID_SOF   = 4'd5; // Host frame start

    // Which side of the bus sent the packet
    typedef enum logic {
        DIR_HOST   = 1'b0,
        DIR_DEVICE = 1'b1
    } dir_t;

    //////////////////////////////////////////////////
    // Time and event counts
    //////////////////////////////////////////////////

    typedef logic [31:0] ts_t;        // Free-running ticks
    typedef logic [15:0] ts_short_t;  // Low half, kept per entry
    typedef logic [15:0] cnt16_t;     // Wraps at 16 bits

    // Buffer entry layout {dir, sop, eop, ts, data}
    localparam int ENTRY_W = 3 + $bits(ts_short_t) + $bits(byte_t);

endpackage
